// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_en_t;   // All zero on a load

    typedef struct packed {
        addr_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } cpu_req_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } rd_beat_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } wr_beat_t;

    // Byte lanes with be set take new_w, the rest keep old_w
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, byte_en_t be);
        word_t res;
        for (int i = 0; i < 4; i++) begin
            res[8*i +: 8] = be[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== dcache_tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store #(
    parameter int INDEX_BITS  = 7,
    parameter int OFFSET_BITS = 4
) (
    input  wire                clk,
    input  wire                rst,
    input  wire dcache_pkg::addr_t lookup_addr,
    output logic               hit,
    output logic               victim_dirty,
    output dcache_pkg::addr_t  victim_addr,
    input  wire                fill_we,
    input  wire                fill_dirty,
    input  wire                mark_dirty
);

    localparam int TAG_BITS = 30 - INDEX_BITS - OFFSET_BITS;
    localparam int LINES    = 1 << INDEX_BITS;

    logic [LINES-1:0]    valid_q;
    logic [LINES-1:0]    dirty_q;
    logic [TAG_BITS-1:0] tag_mem [LINES];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;

    assign index = lookup_addr[OFFSET_BITS+2 +: INDEX_BITS];
    assign tag   = lookup_addr[31 -: TAG_BITS];

    assign hit          = valid_q[index] && (tag_mem[index] == tag);
    assign victim_dirty = dirty_q[index];
    assign victim_addr  = {tag_mem[index], index, {(OFFSET_BITS+2){1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_we) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= fill_dirty;
        end else if (mark_dirty) begin
            dirty_q[index] <= 1'b1;   // Store hit
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) tag_mem[index] <= tag;
    end

endmodule

`default_nettype wire

// ==== dcache_line_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_line_ram #(
    parameter  int INDEX_BITS  = 7,
    parameter  int OFFSET_BITS = 4,
    localparam int WORDS       = 1 << OFFSET_BITS
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire dcache_pkg::addr_t             index_addr,
    output dcache_pkg::word_t [WORDS-1:0]      line_rd,
    input  wire                                line_we,
    input  wire dcache_pkg::word_t [WORDS-1:0] line_wd,
    input  wire                                word_we,
    input  wire dcache_pkg::cpu_req_t          store
);

    localparam int LINES = 1 << INDEX_BITS;

    dcache_pkg::word_t [WORDS-1:0] mem [LINES];

    logic [INDEX_BITS-1:0]  index;
    logic [OFFSET_BITS-1:0] offset;

    assign index  = index_addr[OFFSET_BITS+2 +: INDEX_BITS];
    assign offset = store.addr[2 +: OFFSET_BITS];

    // Whole line, asynchronous read
    assign line_rd = mem[index];

    always_ff @(posedge clk) begin
        if (line_we) begin
            mem[index] <= line_wd;
        end else if (word_we) begin
            mem[index][offset] <= dcache_pkg::merge_bytes(mem[index][offset],
                                                          store.wdata, store.byte_en);
        end
    end

    // Refill and store hit come from different controller states
    a_one_write: assert property (@(posedge clk) disable iff (rst) !(line_we && word_we));

endmodule

`default_nettype wire

// ==== dcache_refill_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_refill_buffer #(
    parameter  int OFFSET_BITS = 4,
    localparam int WORDS       = 1 << OFFSET_BITS
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           clear,
    input  wire                           rvalid,
    input  wire dcache_pkg::rd_beat_t     rd_beat,
    input  wire dcache_pkg::cpu_req_t     store,
    output dcache_pkg::word_t [WORDS-1:0] refill_line
);

    logic [OFFSET_BITS-1:0] beat_cnt;
    logic                   merge_here;

    assign merge_here = (beat_cnt == store.addr[2 +: OFFSET_BITS]) && (|store.byte_en);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            beat_cnt <= '0;
        end else if (rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Each beat into its word slot
    always_ff @(posedge clk) begin
        if (rvalid) begin
            if (merge_here) begin
                refill_line[beat_cnt] <= dcache_pkg::merge_bytes(rd_beat.data,
                                                                 store.wdata,
                                                                 store.byte_en);
            end else begin
                refill_line[beat_cnt] <= rd_beat.data;
            end
        end
    end

    // Memory must send exactly one line per burst
    a_last_aligned: assert property (@(posedge clk) disable iff (rst)
        (rvalid && rd_beat.last) |-> (&beat_cnt));

endmodule

`default_nettype wire

// ==== dcache_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_writeback #(
    parameter  int OFFSET_BITS = 4,
    localparam int WORDS       = 1 << OFFSET_BITS
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                start,
    input  wire dcache_pkg::addr_t             victim_addr,
    input  wire dcache_pkg::word_t [WORDS-1:0] line_rd,
    output logic                               wr_req,
    output dcache_pkg::addr_t                  wr_addr,
    input  wire                                wr_req_ok,
    output logic                               wvalid,
    output dcache_pkg::wr_beat_t               wr_beat,
    input  wire                                wready,
    input  wire                                bvalid,
    output logic                               busy
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_SHAKE,
        W_DATA,
        W_RESP
    } wb_state_t;

    wb_state_t              state;
    logic [OFFSET_BITS-1:0] beat_cnt;
    dcache_pkg::addr_t      addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= W_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                W_IDLE: if (start) state <= W_SHAKE;
                W_SHAKE: begin
                    beat_cnt <= '0;
                    if (wr_req_ok) state <= W_DATA;
                end
                W_DATA: if (wready) begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (wr_beat.last) state <= W_RESP;
                end
                W_RESP: if (bvalid) state <= W_IDLE;
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) addr_q <= victim_addr;
    end

    assign busy         = (state != W_IDLE);
    assign wr_req       = (state == W_SHAKE);
    assign wr_addr      = addr_q;
    assign wvalid       = (state == W_DATA);
    assign wr_beat.data = line_rd[beat_cnt];  // Line RAM held until busy falls
    assign wr_beat.last = &beat_cnt;

    a_no_restart: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter  int OFFSET_BITS = 4,
    localparam int WORDS       = 1 << OFFSET_BITS
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                req,
    input  wire dcache_pkg::cpu_req_t          cpu_req,
    output logic                               data_ok,
    output dcache_pkg::word_t                  rdata,
    input  wire                                hit,
    input  wire                                victim_dirty,
    input  wire dcache_pkg::word_t [WORDS-1:0] line_rd,
    input  wire dcache_pkg::word_t [WORDS-1:0] refill_line,
    output logic                               rd_req,
    output dcache_pkg::addr_t                  rd_addr,
    input  wire                                rd_req_ok,
    input  wire                                rvalid,
    input  wire dcache_pkg::rd_beat_t          rd_beat,
    output logic                               wb_start,
    input  wire                                wb_busy,
    output logic                               line_we,
    output logic                               word_we,
    output logic                               fill_we,
    output logic                               fill_dirty,
    output logic                               mark_dirty,
    output logic                               refill_clear
);

    typedef enum logic [2:0] {
        IDLE,
        RSHAKE,
        RWAIT,
        WWAIT,
        REFILL
    } state_t;

    state_t                 state, next;
    logic [OFFSET_BITS-1:0] offset;
    logic                   is_store;

    assign offset   = cpu_req.addr[2 +: OFFSET_BITS];
    assign is_store = |cpu_req.byte_en;
    assign rd_addr  = {cpu_req.addr[31:OFFSET_BITS+2], {(OFFSET_BITS+2){1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) state <= IDLE;
        else     state <= next;
    end

    always_comb begin
        next         = state;
        data_ok      = 1'b0;
        rdata        = '0;
        rd_req       = 1'b0;
        wb_start     = 1'b0;
        line_we      = 1'b0;
        word_we      = 1'b0;
        fill_we      = 1'b0;
        fill_dirty   = 1'b0;
        mark_dirty   = 1'b0;
        refill_clear = 1'b0;
        case (state)
            IDLE: if (req) begin
                if (hit) begin
                    data_ok = 1'b1;
                    if (is_store) begin
                        word_we    = 1'b1;
                        mark_dirty = 1'b1;
                    end else begin
                        rdata = line_rd[offset];
                    end
                end else begin
                    rd_req       = 1'b1;
                    refill_clear = 1'b1;
                    wb_start     = victim_dirty;  // Victim line still in RAM
                    next         = rd_req_ok ? RWAIT : RSHAKE;
                end
            end
            RSHAKE: begin
                rd_req = 1'b1;
                if (rd_req_ok) next = RWAIT;
            end
            RWAIT: if (rvalid && rd_beat.last) next = wb_busy ? WWAIT : REFILL;
            WWAIT: if (!wb_busy) next = REFILL;
            REFILL: begin
                line_we    = 1'b1;
                fill_we    = 1'b1;
                fill_dirty = is_store;        // Store already merged in buffer
                data_ok    = 1'b1;
                rdata      = refill_line[offset];
                next       = IDLE;
            end
            default: next = IDLE;
        endcase
    end

    a_rd_req_hold: assert property (@(posedge clk) disable iff (rst)
        (rd_req && !rd_req_ok) |=> (rd_req && $stable(rd_addr)));

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter  int INDEX_BITS  = 7,
    parameter  int OFFSET_BITS = 4,
    localparam int WORDS       = 1 << OFFSET_BITS
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       req,
    input  wire dcache_pkg::cpu_req_t cpu_req,
    output logic                      data_ok,
    output dcache_pkg::word_t         rdata,
    // Read channel
    output logic                      rd_req,
    output dcache_pkg::addr_t         rd_addr,
    input  wire                       rd_req_ok,
    input  wire                       rvalid,
    input  wire dcache_pkg::rd_beat_t rd_beat,
    // Write channel
    output logic                      wr_req,
    output dcache_pkg::addr_t         wr_addr,
    input  wire                       wr_req_ok,
    output logic                      wvalid,
    output dcache_pkg::wr_beat_t      wr_beat,
    input  wire                       wready,
    input  wire                       bvalid
);

    logic                          hit, victim_dirty;
    dcache_pkg::addr_t             victim_addr;
    dcache_pkg::word_t [WORDS-1:0] line_rd, refill_line;
    logic                          line_we, word_we, fill_we, fill_dirty, mark_dirty;
    logic                          refill_clear, wb_start, wb_busy;

    dcache_ctrl #(.OFFSET_BITS(OFFSET_BITS)) ctrl0 (
        .clk, .rst, .req, .cpu_req, .data_ok, .rdata, .hit, .victim_dirty,
        .line_rd, .refill_line, .rd_req, .rd_addr, .rd_req_ok, .rvalid, .rd_beat,
        .wb_start, .wb_busy, .line_we, .word_we, .fill_we, .fill_dirty,
        .mark_dirty, .refill_clear
    );

    dcache_tag_store #(.INDEX_BITS(INDEX_BITS), .OFFSET_BITS(OFFSET_BITS)) tags0 (
        .clk, .rst, .lookup_addr(cpu_req.addr), .hit, .victim_dirty, .victim_addr,
        .fill_we, .fill_dirty, .mark_dirty
    );

    dcache_line_ram #(.INDEX_BITS(INDEX_BITS), .OFFSET_BITS(OFFSET_BITS)) ram0 (
        .clk, .rst, .index_addr(cpu_req.addr), .line_rd, .line_we,
        .line_wd(refill_line), .word_we, .store(cpu_req)
    );

    dcache_refill_buffer #(.OFFSET_BITS(OFFSET_BITS)) refill0 (
        .clk, .rst, .clear(refill_clear), .rvalid, .rd_beat, .store(cpu_req),
        .refill_line
    );

    dcache_writeback #(.OFFSET_BITS(OFFSET_BITS)) wb0 (
        .clk, .rst, .start(wb_start), .victim_addr, .line_rd, .wr_req, .wr_addr,
        .wr_req_ok, .wvalid, .wr_beat, .wready, .bvalid, .busy(wb_busy)
    );

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
    parameter int OFFSET_BITS = 4,
    parameter int MEM_WORDS   = 1024
) (
    input  wire                       clk,
    input  wire                       rd_req,
    input  wire dcache_pkg::addr_t    rd_addr,
    output logic                      rd_req_ok,
    output logic                      rvalid,
    output dcache_pkg::rd_beat_t      rd_beat,
    input  wire                       wr_req,
    input  wire dcache_pkg::addr_t    wr_addr,
    output logic                      wr_req_ok,
    input  wire                       wvalid,
    input  wire dcache_pkg::wr_beat_t wr_beat,
    output logic                      wready,
    output logic                      bvalid
);

    localparam int WORDS = 1 << OFFSET_BITS;

    dcache_pkg::word_t mem [MEM_WORDS];

    function automatic dcache_pkg::word_t init_word(dcache_pkg::addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    // Stalls 0 to 3 cycles and resumes 1 ns after an edge
    task automatic random_gap();
        int n;
        n = $urandom % 4;
        if (n > 0) begin
            repeat (n) @(posedge clk);
            #1;
        end
    endtask

    task automatic read_channel();
        int base;
        forever begin
            @(negedge clk);
            if (rd_req) begin
                base = (rd_addr >> 2) % MEM_WORDS;
                random_gap();
                @(posedge clk);
                #1 rd_req_ok = 1'b1;
                @(posedge clk);
                #1 rd_req_ok = 1'b0;
                for (int i = 0; i < WORDS; i++) begin
                    random_gap();
                    rvalid       = 1'b1;
                    rd_beat.data = mem[base + i];
                    rd_beat.last = (i == WORDS - 1);
                    @(posedge clk);
                    #1 rvalid = 1'b0;
                end
            end
        end
    endtask

    task automatic write_channel();
        int   base;
        int   i;
        logic done;
        forever begin
            @(negedge clk);
            if (wr_req) begin
                base = (wr_addr >> 2) % MEM_WORDS;
                random_gap();
                @(posedge clk);
                #1 wr_req_ok = 1'b1;
                @(posedge clk);
                #1 wr_req_ok = 1'b0;
                i    = 0;
                done = 1'b0;
                while (!done) begin
                    random_gap();
                    wready = 1'b1;
                    @(negedge clk);
                    if (wvalid) begin  // Beat moves on the coming edge
                        mem[base + i] = wr_beat.data;
                        done          = wr_beat.last;
                        i++;
                    end
                    @(posedge clk);
                    #1 wready = 1'b0;
                end
                random_gap();
                bvalid = 1'b1;
                @(posedge clk);
                #1 bvalid = 1'b0;
            end
        end
    endtask

    initial begin
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem[k] = init_word(k << 2);
        end
        rd_req_ok = 1'b0;
        rvalid    = 1'b0;
        rd_beat   = '0;
        wr_req_ok = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        void'($urandom(99));  // Both channel threads draw from this seed
        fork
            read_channel();
            write_channel();
        join
    end

endmodule

`default_nettype wire

// ==== dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int INDEX_BITS  = 3;
    localparam int OFFSET_BITS = 4;
    // Five misses with up to two 16-beat bursts at 4 cycles a beat plus wide margin
    localparam int MAX_CYCLES  = 20000;

    logic                 clk;
    logic                 rst;
    logic                 req;
    dcache_pkg::cpu_req_t cpu_req;
    logic                 data_ok;
    dcache_pkg::word_t    rdata;
    logic                 rd_req, rd_req_ok, rvalid;
    logic                 wr_req, wr_req_ok, wvalid, wready, bvalid;
    dcache_pkg::addr_t    rd_addr, wr_addr;
    dcache_pkg::rd_beat_t rd_beat;
    dcache_pkg::wr_beat_t wr_beat;
    int                   cycle_cnt;

    dcache_top #(.INDEX_BITS(INDEX_BITS), .OFFSET_BITS(OFFSET_BITS)) dut0 (
        .clk, .rst, .req, .cpu_req, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_req_ok, .rvalid, .rd_beat,
        .wr_req, .wr_addr, .wr_req_ok, .wvalid, .wr_beat, .wready, .bvalid
    );

    tb_mem_model #(.OFFSET_BITS(OFFSET_BITS)) mem0 (
        .clk, .rd_req, .rd_addr, .rd_req_ok, .rvalid, .rd_beat,
        .wr_req, .wr_addr, .wr_req_ok, .wvalid, .wr_beat, .wready, .bvalid
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: no response from the cache within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    // Address xor its half-swapped self xor a constant
    function automatic dcache_pkg::word_t mem_init_word(dcache_pkg::addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic dcache_pkg::word_t lane_merge(dcache_pkg::word_t old_w,
                                                     dcache_pkg::word_t new_w,
                                                     dcache_pkg::byte_en_t be);
        dcache_pkg::word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic check_word(input string name, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Request held until data_ok while first_ok takes data_ok in the request cycle
    task automatic cache_access(input dcache_pkg::addr_t a, input dcache_pkg::word_t wd,
                                input dcache_pkg::byte_en_t be,
                                output dcache_pkg::word_t rd, output logic first_ok);
        @(posedge clk);
        #1;
        req             = 1'b1;
        cpu_req.addr    = a;
        cpu_req.wdata   = wd;
        cpu_req.byte_en = be;
        @(negedge clk);
        first_ok = data_ok;
        while (!data_ok) @(negedge clk);
        rd = rdata;
        @(posedge clk);
        #1 req = 1'b0;
    endtask

    task automatic test_load_miss();
        dcache_pkg::word_t rd;
        logic              first;
        cache_access(32'h0000_0104, '0, 4'b0000, rd, first);
        check_flag("data_ok", first, 1'b0);
        check_word("rdata", rd, mem_init_word(32'h0000_0104));
    endtask

    task automatic test_load_hit();
        dcache_pkg::word_t rd;
        logic              first;
        cache_access(32'h0000_0138, '0, 4'b0000, rd, first);
        check_flag("data_ok", first, 1'b1);  // Zero-latency hit
        check_word("rdata", rd, mem_init_word(32'h0000_0138));
    endtask

    task automatic test_store_hit();
        dcache_pkg::word_t rd;
        logic              first;
        cache_access(32'h0000_0104, 32'hdead_beef, 4'b0101, rd, first);
        check_flag("data_ok", first, 1'b1);
        cache_access(32'h0000_0104, '0, 4'b0000, rd, first);
        check_flag("data_ok", first, 1'b1);
        check_word("rdata", rd,
                   lane_merge(mem_init_word(32'h0000_0104), 32'hdead_beef, 4'b0101));
    endtask

    task automatic test_store_miss();
        dcache_pkg::word_t rd;
        logic              first;
        cache_access(32'h0000_0288, 32'h1234_5678, 4'b1100, rd, first);
        check_flag("data_ok", first, 1'b0);
        cache_access(32'h0000_0288, '0, 4'b0000, rd, first);
        check_word("rdata", rd,
                   lane_merge(mem_init_word(32'h0000_0288), 32'h1234_5678, 4'b1100));
        cache_access(32'h0000_0280, '0, 4'b0000, rd, first);
        check_word("rdata", rd, mem_init_word(32'h0000_0280));
        cache_access(32'h0000_02bc, '0, 4'b0000, rd, first);
        check_word("rdata", rd, mem_init_word(32'h0000_02bc));
    endtask

    task automatic test_evict();
        dcache_pkg::word_t rd;
        logic              first;
        dcache_pkg::addr_t a;
        dcache_pkg::word_t exp;
        // Index 2 under a new tag evicts the dirty line at 0x280
        cache_access(32'h0000_048c, '0, 4'b0000, rd, first);
        check_flag("data_ok", first, 1'b0);
        check_word("rdata", rd, mem_init_word(32'h0000_048c));
        for (int w = 0; w < (1 << OFFSET_BITS); w++) begin
            a   = 32'h0000_0280 + 4 * w;
            exp = mem_init_word(a);
            if (a == 32'h0000_0288) exp = lane_merge(exp, 32'h1234_5678, 4'b1100);
            check_word("mem0.mem", mem0.mem[a >> 2], exp);
        end
        // Index 4 was dirtied by the store hit
        cache_access(32'h0000_0504, '0, 4'b0000, rd, first);
        check_word("rdata", rd, mem_init_word(32'h0000_0504));
        check_word("mem0.mem", mem0.mem[32'h104 >> 2],
                   lane_merge(mem_init_word(32'h0000_0104), 32'hdead_beef, 4'b0101));
        check_word("mem0.mem", mem0.mem[32'h138 >> 2], mem_init_word(32'h0000_0138));
        cache_access(32'h0000_0288, '0, 4'b0000, rd, first);  // Clean victim so refetch only
        check_word("rdata", rd,
                   lane_merge(mem_init_word(32'h0000_0288), 32'h1234_5678, 4'b1100));
    endtask

    initial begin
        cycle_cnt = 0;
        rst       = 1'b1;
        req       = 1'b0;
        cpu_req   = '0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        test_load_miss();
        test_load_hit();
        test_store_hit();
        test_store_miss();
        test_evict();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
dcache_pkg.sv
dcache_tag_store.sv
dcache_line_ram.sv
dcache_refill_buffer.sv
dcache_writeback.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
dcache_tb.sv
